// ==== src/alu_pkg.sv ====
/*
 * ALU package
 * widths, opcodes, control bus and co-processor result types
 * shared by the integer ALU slice and its co-processors
 */
package alu_pkg;

    // ------------------------------------------------------------------------
    // widths and indices
    // ------------------------------------------------------------------------
    localparam int xlen_c       = 32; // data path width
    localparam int shamt_w_c    = 5;  // shift amount width
    localparam int cp_num_c     = 2;  // number of co-processors
    localparam int cp_shift_c   = 0;  // trigger bit of the shifter
    localparam int cp_cond_c    = 1;  // trigger bit of the conditional unit
    localparam int cp_timeout_c = 4;  // timeout counter msb, ~16 cycles
    localparam int cmp_equal_c  = 0;  // comparator status: rs1 == rs2
    localparam int cmp_less_c   = 1;  // comparator status: rs1 < rs2

    typedef logic [xlen_c-1:0] word_t;

    // ------------------------------------------------------------------------
    // opcodes
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        alu_op_add_c  = 3'b000,
        alu_op_sub_c  = 3'b001,
        alu_op_cp_c   = 3'b010, // co-processor result
        alu_op_slt_c  = 3'b011,
        alu_op_movb_c = 3'b100, // pass operand b
        alu_op_xor_c  = 3'b101,
        alu_op_or_c   = 3'b110,
        alu_op_and_c  = 3'b111
    } alu_op_t;

    typedef logic [1:0] cp_func_t;

    localparam cp_func_t cp_sll_c       = 2'd0; // shifter functions
    localparam cp_func_t cp_srl_c       = 2'd1;
    localparam cp_func_t cp_sra_c       = 2'd2;
    localparam cp_func_t cp_czero_eqz_c = 2'd0; // conditional unit functions
    localparam cp_func_t cp_czero_nez_c = 2'd1;

    // ------------------------------------------------------------------------
    // control bus and co-processor output
    // ------------------------------------------------------------------------
    typedef struct packed {
        alu_op_t               alu_op;       // result select
        logic                  opa_mux;      // 1: pc, 0: rs1
        logic                  opb_mux;      // 1: imm, 0: rs2
        logic                  alu_unsigned; // unsigned compare/add
        logic [cp_num_c-1:0]   cp_trig;      // one-cycle co-processor start
        cp_func_t              cp_func;      // co-processor function
        logic                  trap;         // abort running operation
    } ctrl_t;

    typedef struct packed {
        logic  valid; // one cycle before res
        word_t res;   // zero unless just finished
    } cp_out_t;

endpackage

// ==== src/alu_datapath.sv ====
/*
 * ALU datapath
 * branch comparator, operand select, 33-bit adder/subtracter
 * and the combinational result select
 */
`timescale 1ns/10ps

module alu_datapath import alu_pkg::*; (
    input  ctrl_t      ctrl_i,   // control bus
    input  word_t      rs1_i,    // register source 1
    input  word_t      rs2_i,    // register source 2
    input  word_t      pc_i,     // current pc
    input  word_t      imm_i,    // immediate
    input  word_t      cp_res_i, // ORed co-processor result
    output word_t      opb_o,    // operand b to co-processors
    output word_t      res_o,    // ALU result
    output word_t      add_o,    // address result
    output logic [1:0] cmp_o     // comparator status
);

    logic [xlen_c:0] cmp_rs1;    // sign/zero extended compare operands
    logic [xlen_c:0] cmp_rs2;
    word_t           opa;
    word_t           opb;
    logic [xlen_c:0] opa_x;      // extended adder operands
    logic [xlen_c:0] opb_x;
    logic [xlen_c:0] addsub_res;
    logic            do_sub;

    // ---------------------------------------------------------------------------
    // comparator
    // ---------------------------------------------------------------------------
    assign cmp_rs1 = {rs1_i[xlen_c-1] & ~ctrl_i.alu_unsigned, rs1_i}; // extend by mode
    assign cmp_rs2 = {rs2_i[xlen_c-1] & ~ctrl_i.alu_unsigned, rs2_i};

    assign cmp_o[cmp_equal_c] = (rs1_i == rs2_i);
    assign cmp_o[cmp_less_c]  = ($signed(cmp_rs1) < $signed(cmp_rs2)); // 33-bit signed

    // ---------------------------------------------------------------------------
    // operand select and adder
    // ---------------------------------------------------------------------------
    assign opa   = ctrl_i.opa_mux ? pc_i  : rs1_i;
    assign opb   = ctrl_i.opb_mux ? imm_i : rs2_i;
    assign opb_o = opb;

    assign opa_x  = {opa[xlen_c-1] & ~ctrl_i.alu_unsigned, opa};
    assign opb_x  = {opb[xlen_c-1] & ~ctrl_i.alu_unsigned, opb};
    assign do_sub = (ctrl_i.alu_op == alu_op_sub_c) || (ctrl_i.alu_op == alu_op_slt_c);

    always_comb begin
        if (do_sub) begin
            addsub_res = opa_x - opb_x;  // slt reads the sign bit
        end else begin
            addsub_res = opa_x + opb_x;
        end
    end

    assign add_o = addsub_res[xlen_c-1:0]; // address output

    // ---------------------------------------------------------------------------
    // result select
    // ---------------------------------------------------------------------------
    always_comb begin
        unique case (ctrl_i.alu_op)
            alu_op_add_c:  res_o = addsub_res[xlen_c-1:0];
            alu_op_sub_c:  res_o = addsub_res[xlen_c-1:0];
            alu_op_cp_c:   res_o = cp_res_i;
            alu_op_slt_c:  res_o = {{(xlen_c-1){1'b0}}, addsub_res[xlen_c]};
            alu_op_movb_c: res_o = opb;
            alu_op_xor_c:  res_o = rs1_i ^ opb;
            alu_op_or_c:   res_o = rs1_i | opb;
            alu_op_and_c:  res_o = rs1_i & opb;
            default:       res_o = addsub_res[xlen_c-1:0];
        endcase
    end

endmodule

// ==== src/cp_monitor.sv ====
/*
 * co-processor monitor
 * tracks a running co-processor operation and raises a one-cycle
 * timeout exception, cleared by the registered done or by a trap
 */
`timescale 1ns/10ps

module cp_monitor import alu_pkg::*; (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic [cp_num_c-1:0] trig_i, // co-processor start pulses
    input  logic                done_i, // any co-processor valid
    input  logic                trap_i, // abort
    output logic                exc_o   // timeout exception
);

    logic                  run;  // operation in progress
    logic                  fin;  // registered done
    logic                  exc;
    logic [cp_timeout_c:0] cnt;  // cycles while running
    logic                  tmo;  // first cycle with msb set

    // only the cycle the msb turns on, so exc stays one cycle wide
    assign tmo = cnt[cp_timeout_c] & ~(|cnt[cp_timeout_c-1:0]);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            run <= 1'b0;
            fin <= 1'b0;
            exc <= 1'b0;
            cnt <= '0;
        end else begin
            exc <= run & tmo & ~fin;
            fin <= done_i;
            if (!run) begin
                cnt <= '0;
                if (|trig_i) begin
                    run <= 1'b1;                 // start tracking
                end
            end else begin
                cnt <= cnt + 1'b1;
                if (fin || trap_i) begin
                    run <= 1'b0;                 // done or abort
                end
            end
        end
    end

    assign exc_o = exc;

endmodule

// ==== src/cp_shifter.sv ====
/*
 * serial shifter co-processor
 * sll, srl and sra, one bit position per cycle
 */
`timescale 1ns/10ps

module cp_shifter import alu_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 start_i, // one-cycle trigger
    input  cp_func_t             func_i,  // shift type
    input  word_t                rs1_i,   // value to shift
    input  logic [shamt_w_c-1:0] shamt_i, // shift amount
    output cp_out_t              out_o
);

    logic                 busy;   // shifting
    logic                 done;   // result cycle
    logic [shamt_w_c-1:0] cnt;    // remaining steps
    word_t                sreg;   // shift register
    cp_func_t             func_q;
    logic                 last;   // count exhausted

    assign last = busy & (cnt == '0);

    // control
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= last;                    // result one cycle after valid
            if (start_i) begin
                busy <= 1'b1;
                cnt  <= shamt_i;
            end else if (last) begin
                busy <= 1'b0;
            end else if (busy) begin
                cnt  <= cnt - 1'b1;
            end
        end
    end

    // data
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            sreg   <= rs1_i;
            func_q <= func_i;
        end else if (busy && !last) begin
            case (func_q)
                cp_sll_c: sreg <= {sreg[xlen_c-2:0], 1'b0};
                cp_srl_c: sreg <= {1'b0, sreg[xlen_c-1:1]};
                cp_sra_c: sreg <= {sreg[xlen_c-1], sreg[xlen_c-1:1]}; // keep sign
                default:  sreg <= {1'b0, sreg[xlen_c-1:1]};
            endcase
        end
    end

    assign out_o.valid = last;
    assign out_o.res   = done ? sreg : '0; // zero outside result cycle

endmodule

// ==== src/cp_cond.sv ====
/*
 * conditional-zero co-processor
 * czero.eqz and czero.nez, result two cycles after start
 */
`timescale 1ns/10ps

module cp_cond import alu_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     start_i, // one-cycle trigger
    input  cp_func_t func_i,  // eqz or nez
    input  word_t    rs1_i,   // value passed through
    input  word_t    rs2_i,   // condition
    output cp_out_t  out_o
);

    logic  busy;      // valid cycle
    logic  done;      // result cycle
    logic  rs2_zero;  // registered zero test
    logic  nez_q;
    word_t rs1_q;
    logic  zero_res;  // result forced to zero

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            busy <= start_i;
            done <= busy;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            rs1_q    <= rs1_i;
            rs2_zero <= (rs2_i == '0);
            nez_q    <= (func_i == cp_czero_nez_c);
        end
    end

    // eqz zeroes on rs2 == 0, nez on rs2 != 0
    assign zero_res = nez_q ? ~rs2_zero : rs2_zero;

    assign out_o.valid = busy;
    assign out_o.res   = (done && !zero_res) ? rs1_q : '0;

endmodule

// ==== src/alu_top.sv ====
/*
 * ALU top level
 * datapath, co-processor monitor, serial shifter and conditional unit
 */
`timescale 1ns/10ps

module alu_top import alu_pkg::*; (
    input  logic       clk_i,     // clock, rising edge
    input  logic       rstn_i,    // async reset, active low
    input  ctrl_t      ctrl_i,    // control bus
    input  word_t      rs1_i,
    input  word_t      rs2_i,
    input  word_t      pc_i,
    input  word_t      imm_i,
    output word_t      res_o,     // ALU result
    output word_t      add_o,     // address result
    output logic [1:0] cmp_o,     // comparator status
    output logic       exc_o,     // co-processor timeout
    output logic       cp_done_o  // co-processor done pulse
);

    word_t                  opb;
    word_t                  cp_res;
    cp_out_t [cp_num_c-1:0] cp_out;  // one per co-processor

    alu_datapath u_datapath (
        .ctrl_i   (ctrl_i),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .pc_i     (pc_i),
        .imm_i    (imm_i),
        .cp_res_i (cp_res),
        .opb_o    (opb),
        .res_o    (res_o),
        .add_o    (add_o),
        .cmp_o    (cmp_o)
    );

    cp_monitor u_monitor (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .trig_i (ctrl_i.cp_trig),
        .done_i (cp_done_o),
        .trap_i (ctrl_i.trap),
        .exc_o  (exc_o)
    );

    // ---------------------------------------------------------------------------
    // co-processors
    // ---------------------------------------------------------------------------
    cp_shifter u_shifter (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .start_i (ctrl_i.cp_trig[cp_shift_c]),
        .func_i  (ctrl_i.cp_func),
        .rs1_i   (rs1_i),
        .shamt_i (opb[shamt_w_c-1:0]),     // low bits of operand b
        .out_o   (cp_out[cp_shift_c])
    );

    cp_cond u_cond (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .start_i (ctrl_i.cp_trig[cp_cond_c]),
        .func_i  (ctrl_i.cp_func),
        .rs1_i   (rs1_i),
        .rs2_i   (rs2_i),
        .out_o   (cp_out[cp_cond_c])
    );

    // idle co-processors drive zero, so a plain OR merges them
    always_comb begin
        cp_res    = '0;
        cp_done_o = 1'b0;
        for (int i = 0; i < cp_num_c; i++) begin
            cp_res    = cp_res | cp_out[i].res;
            cp_done_o = cp_done_o | cp_out[i].valid;
        end
    end

endmodule

// ==== tests/alu_assertions.sv ====
/*
 * protocol checks on the ALU top level ports
 * reset state, single trigger, done only after a trigger
 */
`timescale 1ns/10ps

module alu_assertions import alu_pkg::*; (
    input logic  clk_i,
    input logic  rstn_i,
    input ctrl_t ctrl_i,
    input logic  exc_o,
    input logic  cp_done_o
);

    logic pending;  // trigger seen, done not yet

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pending <= 1'b0;
        end else if (|ctrl_i.cp_trig) begin
            pending <= 1'b1;
        end else if (cp_done_o) begin
            pending <= 1'b0;
        end
    end

    reset_quiet: assert property (@(posedge clk_i) !rstn_i |-> !exc_o && !cp_done_o)
        else $error("exc_o or cp_done_o high during reset");
    release_quiet: assert property (@(posedge clk_i) $rose(rstn_i) |-> !exc_o && !cp_done_o)
        else $error("exc_o or cp_done_o high right after reset");
    one_trigger: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(ctrl_i.cp_trig)) else $error("more than one cp_trig bit set");
    done_after_trig: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cp_done_o |-> pending) else $error("cp_done_o without a trigger");

endmodule

bind alu_top alu_assertions u_assertions (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .ctrl_i    (ctrl_i),
    .exc_o     (exc_o),
    .cp_done_o (cp_done_o)
);

// ==== tests/tb_alu.sv ====
/*
 * testbench for the ALU slice
 * random and directed datapath checks, co-processor runs,
 * timeout exception and trap abort
 */
`timescale 1ns/10ps

module tb_alu import alu_pkg::*; ();

    typedef struct packed {
        word_t       res;   // expected res_o
        word_t       add;   // expected add_o
        logic [1:0]  cmp;   // expected cmp_o
        word_t       cp;    // expected co-processor result
    } exp_t;

    logic       clk_i;
    logic       rstn_i;
    ctrl_t      ctrl;
    word_t      rs1;
    word_t      rs2;
    word_t      pc;
    word_t      imm;
    word_t      res;
    word_t      add;
    logic [1:0] cmp;
    logic       exc;
    logic       cp_done;
    logic       checking;       // compare process enable
    int         seed = 78;

    alu_top DUT (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .ctrl_i    (ctrl),
        .rs1_i     (rs1),
        .rs2_i     (rs2),
        .pc_i      (pc),
        .imm_i     (imm),
        .res_o     (res),
        .add_o     (add),
        .cmp_o     (cmp),
        .exc_o     (exc),
        .cp_done_o (cp_done)
    );

    always #5 clk_i = ~clk_i;   // 10 ns period

    // ------------------------------------------------------------------------
    // reporting and reference model
    // ------------------------------------------------------------------------
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            stop_run("mismatch");
        end
    endtask

    function automatic ctrl_t make_ctrl(alu_op_t op, logic amux, logic bmux, logic uns);
        ctrl_t c;
        c              = '0;
        c.alu_op       = op;
        c.opa_mux      = amux;
        c.opb_mux      = bmux;
        c.alu_unsigned = uns;
        return c;
    endfunction

    function automatic exp_t alu_model(ctrl_t c, word_t a, word_t b, word_t p, word_t im);
        exp_t  e;
        word_t opa;
        word_t opb;
        logic  lt;
        int    sh;
        opa = c.opa_mux ? p : a;
        opb = c.opb_mux ? im : b;
        sh  = int'(opb[shamt_w_c-1:0]);
        e.cmp[cmp_equal_c] = (a == b);
        e.cmp[cmp_less_c]  = c.alu_unsigned ? (a < b) : ($signed(a) < $signed(b));
        lt = c.alu_unsigned ? (opa < opb) : ($signed(opa) < $signed(opb)); // slt rule
        if (c.alu_op == alu_op_sub_c || c.alu_op == alu_op_slt_c) e.add = opa - opb;
        else e.add = opa + opb;
        case (c.alu_op)
            alu_op_add_c:  e.res = opa + opb;
            alu_op_sub_c:  e.res = opa - opb;
            alu_op_slt_c:  e.res = 32'(lt);
            alu_op_movb_c: e.res = opb;
            alu_op_xor_c:  e.res = a ^ opb;
            alu_op_or_c:   e.res = a | opb;
            alu_op_and_c:  e.res = a & opb;
            default:       e.res = '0;         // cp result comes later
        endcase
        if (c.cp_trig[cp_shift_c]) begin
            case (c.cp_func)
                cp_sll_c: e.cp = a << sh;
                cp_srl_c: e.cp = a >> sh;
                default:  e.cp = $signed(a) >>> sh;
            endcase
        end else if (c.cp_func == cp_czero_nez_c) begin
            e.cp = (b == '0) ? a : '0;         // zero when rs2 non-zero
        end else begin
            e.cp = (b != '0) ? a : '0;         // zero when rs2 is zero
        end
        return e;
    endfunction

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    // combinational outputs, sampled mid-cycle
    always @(negedge clk_i) begin
        exp_t e;
        if (checking) begin
            e = alu_model(ctrl, rs1, rs2, pc, imm);
            check("add_o", e.add, add);
            check("cmp_o", 32'(e.cmp), 32'(cmp));
            if (ctrl.alu_op != alu_op_cp_c) check("res_o", e.res, res);
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    task automatic drive(input ctrl_t c, input word_t a, input word_t b,
                         input word_t p, input word_t i);
        @(posedge clk_i);
        ctrl <= c;
        rs1  <= a;
        rs2  <= b;
        pc   <= p;
        imm  <= i;
    endtask

    task automatic run_comb();
        ctrl_t c;
        word_t a;
        word_t b;
        for (int k = 0; k < 8; k++) begin
            if (k == int'(alu_op_cp_c)) continue;
            for (int m = 0; m < 8; m++) begin
                for (int r = 0; r < 4; r++) begin
                    c = make_ctrl(alu_op_t'(k), m[0], m[1], m[2]);
                    a = rand_word();
                    b = (r == 0) ? a : rand_word(); // one equal pair per setting
                    drive(c, a, b, rand_word(), rand_word());
                end
            end
        end
    endtask

    task automatic check_edges();
        drive(make_ctrl(alu_op_slt_c, 0, 0, 0), 32'h1234_5678, 32'h1234_5678, pc, imm);
        @(negedge clk_i);
        check("cmp_o", 32'd1, 32'(cmp));                    // equal only
        drive(make_ctrl(alu_op_slt_c, 0, 0, 0), 32'h8000_0000, 32'h0, pc, imm);
        @(negedge clk_i);
        check("cmp_o", 32'd2, 32'(cmp));                    // most negative < 0
        drive(make_ctrl(alu_op_slt_c, 0, 0, 1), 32'h8000_0000, 32'h0, pc, imm);
        @(negedge clk_i);
        check("cmp_o", 32'd0, 32'(cmp));                    // large unsigned
        drive(make_ctrl(alu_op_slt_c, 0, 0, 0), 32'hffff_ffff, 32'h1, pc, imm);
        @(negedge clk_i);
        check("cmp_o", 32'd2, 32'(cmp));                    // -1 < 1
        drive(make_ctrl(alu_op_slt_c, 0, 0, 1), 32'hffff_ffff, 32'h1, pc, imm);
        @(negedge clk_i);
        check("cmp_o", 32'd0, 32'(cmp));
    endtask

    // one co-processor operation, optional trap after trap_after cycles
    task automatic run_cp(input int unit, input cp_func_t func, input word_t a,
                          input word_t b, input logic want_exc, input int trap_after);
        ctrl_t c;
        exp_t  e;
        int    n;
        int    lat;
        int    exc_n;
        logic  done;
        c             = make_ctrl(alu_op_cp_c, 0, 0, 0);
        c.cp_trig     = 2'(1 << unit);
        c.cp_func     = func;
        e             = alu_model(c, a, b, pc, imm);
        lat           = (unit == cp_shift_c) ? int'(b[shamt_w_c-1:0]) + 1 : 1; // valid cycle
        n             = 0;
        exc_n         = 0;
        done          = 1'b0;
        drive(c, a, b, pc, imm);
        @(posedge clk_i);
        ctrl.cp_trig <= '0;                              // one-cycle start
        while (!done) begin
            @(negedge clk_i);
            if (exc) exc_n++;
            done = cp_done;
            n++;
            if (!done && n > 48) stop_run("timeout: cp_done_o never pulsed");
            if (n == trap_after) begin
                @(posedge clk_i);
                ctrl.trap <= 1'b1;
            end
            if (n == trap_after + 1) begin
                @(posedge clk_i);
                ctrl.trap <= 1'b0;
            end
        end
        @(negedge clk_i);                                // result cycle
        if (exc) exc_n++;
        check("cp_done_o cycle", 32'(lat), 32'(n));
        check("res_o", e.cp, res);
        check("exc_o pulses", 32'(want_exc), 32'(exc_n));
    endtask

    initial begin
        word_t b;
        clk_i    = 1'b0;
        rstn_i   = 1'b0;
        ctrl     = '0;
        rs1      = '0;
        rs2      = '0;
        pc       = '0;
        imm      = '0;
        checking = 1'b0;
        repeat (10) @(posedge clk_i);
        rstn_i   <= 1'b1;
        checking <= 1'b1;
        run_comb();
        check_edges();
        for (int s = 0; s < 12; s++) begin
            b      = rand_word();
            b[4:0] = 5'($unsigned($random(seed)) % 9);     // short shifts
            run_cp(cp_shift_c, cp_func_t'($unsigned($random(seed)) % 3), rand_word(),
                   b, 1'b0, -1);
        end
        for (int f = 0; f < 2; f++) begin
            run_cp(cp_cond_c, cp_func_t'(f), rand_word() | 32'h1, 32'h0, 1'b0, -1);
            run_cp(cp_cond_c, cp_func_t'(f), rand_word() | 32'h1, rand_word() | 32'h4,
                   1'b0, -1);
        end
        run_cp(cp_shift_c, cp_sra_c, 32'h8765_4321, 32'd24, 1'b1, -1); // timeout
        run_cp(cp_shift_c, cp_srl_c, rand_word(), 32'd31, 1'b1, -1);
        run_cp(cp_shift_c, cp_sll_c, rand_word(), 32'd30, 1'b0, 3);    // trap abort
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== verilog.f ====
src/alu_pkg.sv
src/alu_datapath.sv
src/cp_monitor.sv
src/cp_shifter.sv
src/cp_cond.sv
src/alu_top.sv
tests/alu_assertions.sv
tests/tb_alu.sv

// ==== Makefile ====
# Verilator build and run of the ALU slice testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run tb_alu"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --assert -Wno-fatal --top-module tb_alu -f verilog.f -o Vtb_alu
	./obj_dir/Vtb_alu | tee sim.log
	@if grep -q "Done: errors found" sim.log; then echo "test FAILED"; exit 1; fi
	@grep -q "Done: no errors" sim.log || (echo "test FAILED: run did not complete"; exit 1)
	@echo "test passed"

clean:
	rm -rf obj_dir sim.log
